// File: hw/icachePkg.sv
// ---------------------------------------------------------------------------
// Shared widths, handshake payload structs and enums of the instruction
// cache. Referenced by scoped name from the controller, array and top level.
// ---------------------------------------------------------------------------
package icachePkg;

    // fetch address and instruction word
    localparam int addrBits = 32;
    localparam int wordBits = 32;

    // block geometry, word 0 sits in the low bits
    localparam int blockWords = 4;
    localparam int blockBits = blockWords * wordBits;
    localparam int wordSelBits = $clog2(blockWords);

    // byte address minus word offset and byte bits
    localparam int blockAddrBits = addrBits - wordSelBits - 2;

    // request from the fetch unit, bits 1:0 of addr are ignored
    typedef struct packed {
        logic [addrBits-1:0] addr;
    } fetchReqT;

    // answer to the fetch unit
    typedef struct packed {
        logic [wordBits-1:0] data;
        // word served without a refill
        logic                hit;
    } fetchRspT;

    // block request toward backing memory
    typedef struct packed {
        logic [blockAddrBits-1:0] blockAddr;
    } refillReqT;

    // block returned by backing memory
    typedef struct packed {
        logic [blockBits-1:0] block;
    } refillRspT;

    // fetch controller states
    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stRefillReq,
        stRefillDrop,
        stFill,
        stRespond
    } fetchStateT;

    // operation the controller asks of the array
    typedef enum logic [1:0] {
        opNone,
        opRead,
        opFill
    } arrayOpT;

endpackage

// File: hw/icacheArray.sv
// ---------------------------------------------------------------------------
// Set-associative tag/data store with combinational hit and block read,
// MRU-bit pseudo-LRU victim choice and a synchronous block fill.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module icacheArray #(
    parameter int setCount = 16,
    parameter int wayCount = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  icachePkg::arrayOpT                  op,
    input  logic [icachePkg::blockAddrBits-1:0] lookupAddr,
    input  logic [icachePkg::blockBits-1:0]     fillBlock,
    output logic                                hit,
    output logic [icachePkg::blockBits-1:0]     hitBlock
);

    localparam int indexBits = $clog2(setCount);
    localparam int tagBits = icachePkg::blockAddrBits - indexBits;

    // block address is {tag, index}
    logic [indexBits-1:0] index;
    logic [tagBits-1:0]   tag;

    // per-set columns
    logic [wayCount-1:0] validCol  [setCount];
    logic [wayCount-1:0] statusCol [setCount];

    // per-way payload
    logic [tagBits-1:0]              tagCol  [setCount][wayCount];
    logic [icachePkg::blockBits-1:0] dataCol [setCount][wayCount];

    logic [wayCount-1:0] wayMatch;
    logic [wayCount-1:0] victim;
    logic [wayCount-1:0] touched;
    logic [wayCount-1:0] nextStatus;
    logic                doRead;
    logic                doFill;

    assign index = lookupAddr[indexBits-1:0];
    assign tag   = lookupAddr[icachePkg::blockAddrBits-1:indexBits];

    // tag compare across the selected set
    always_comb begin
        hitBlock = '0;
        for (int w = 0; w < wayCount; w++) begin
            wayMatch[w] = validCol[index][w] && (tagCol[index][w] == tag);
            if (wayMatch[w]) begin
                hitBlock = dataCol[index][w];
            end
        end
    end

    assign hit = |wayMatch;

    // victim: first invalid way, else first way not recently used
    always_comb begin
        logic found;
        found = 1'b0;
        victim = '0;
        if (!(&validCol[index])) begin
            for (int w = 0; w < wayCount; w++) begin
                if (!found && !validCol[index][w]) begin
                    victim[w] = 1'b1;
                    found = 1'b1;
                end
            end
        end else begin
            for (int w = 0; w < wayCount; w++) begin
                if (!found && !statusCol[index][w]) begin
                    victim[w] = 1'b1;
                    found = 1'b1;
                end
            end
        end
    end

    assign doRead = (op == icachePkg::opRead) && hit;
    assign doFill = (op == icachePkg::opFill);

    // way touched by this access
    assign touched = doFill ? victim : wayMatch;

    // set the MRU bit, start a new round once every bit would be set
    always_comb begin
        nextStatus = statusCol[index] | touched;
        if (&nextStatus) begin
            nextStatus = touched;
        end
    end

    // valid and status bits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < setCount; s++) begin
                validCol[s]  <= '0;
                statusCol[s] <= '0;
            end
        end else begin
            if (doFill) begin
                validCol[index] <= validCol[index] | victim;
            end
            if (doFill || doRead) begin
                statusCol[index] <= nextStatus;
            end
        end
    end

    // tag and data columns
    always_ff @(posedge clk) begin
        if (doFill) begin
            for (int w = 0; w < wayCount; w++) begin
                if (victim[w]) begin
                    tagCol[index][w]  <= tag;
                    dataCol[index][w] <= fillBlock;
                end
            end
        end
    end

    // a fill never duplicates a resident tag, so matches stay unique
    hitOneWay: assert property (
        @(posedge clk) disable iff (!rst)
        hit |-> $onehot(wayMatch)
    ) else $error("icacheArray: block address matches more than one way");

    // controller only refills after a lookup that missed
    fillOnMiss: assert property (
        @(posedge clk) disable iff (!rst)
        (op == icachePkg::opFill) |-> !hit
    ) else $error("icacheArray: fill issued for a resident block");

endmodule

// File: hw/fetchController.sv
// ---------------------------------------------------------------------------
// Fetch FSM: serves four-phase fetch requests from the array, refills a
// missing block from backing memory and drives the array operations.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module fetchController (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                fetchValid,
    input  icachePkg::fetchReqT                 fetchReq,
    output logic                                fetchAck,
    output icachePkg::fetchRspT                 fetchRsp,
    output logic                                refillValid,
    output icachePkg::refillReqT                refillReq,
    input  logic                                refillAck,
    input  icachePkg::refillRspT                refillRsp,
    output icachePkg::arrayOpT                  op,
    output logic [icachePkg::blockAddrBits-1:0] lookupAddr,
    output logic [icachePkg::blockBits-1:0]     fillBlock,
    input  logic                                hit,
    input  logic [icachePkg::blockBits-1:0]     hitBlock
);

    icachePkg::fetchStateT state;
    icachePkg::fetchStateT nextState;

    logic [icachePkg::addrBits-1:0]    reqAddr;
    logic [icachePkg::wordSelBits-1:0] wordSel;
    logic [icachePkg::blockBits-1:0]   blockReg;

    assign wordSel    = reqAddr[icachePkg::wordSelBits+1:2];
    assign lookupAddr = reqAddr[icachePkg::addrBits-1:icachePkg::wordSelBits+2];

    assign refillReq.blockAddr = lookupAddr;
    assign fillBlock = blockReg;

    // both handshake outputs are decoded from the state register
    assign refillValid = (state == icachePkg::stRefillReq);
    assign fetchAck    = (state == icachePkg::stRespond);

    always_comb begin
        nextState = state;
        case (state)
            icachePkg::stIdle: begin
                if (fetchValid) begin
                    nextState = icachePkg::stLookup;
                end
            end
            icachePkg::stLookup: begin
                nextState = hit ? icachePkg::stRespond : icachePkg::stRefillReq;
            end
            icachePkg::stRefillReq: begin
                if (refillAck) begin
                    nextState = icachePkg::stRefillDrop;
                end
            end
            icachePkg::stRefillDrop: begin
                // wait for memory to finish its half of the handshake
                if (!refillAck) begin
                    nextState = icachePkg::stFill;
                end
            end
            icachePkg::stFill: begin
                nextState = icachePkg::stRespond;
            end
            icachePkg::stRespond: begin
                if (!fetchValid) begin
                    nextState = icachePkg::stIdle;
                end
            end
            default: begin
                nextState = icachePkg::stIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= icachePkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    // array operation per state
    always_comb begin
        case (state)
            icachePkg::stLookup: op = icachePkg::opRead;
            icachePkg::stFill:   op = icachePkg::opFill;
            default:             op = icachePkg::opNone;
        endcase
    end

    // request address, block buffer and response word
    always_ff @(posedge clk) begin
        if (state == icachePkg::stIdle && fetchValid) begin
            reqAddr <= fetchReq.addr;
        end
        if (state == icachePkg::stRefillReq && refillAck) begin
            blockReg <= refillRsp.block;
        end
        if (state == icachePkg::stLookup && hit) begin
            fetchRsp.data <= hitBlock[wordSel*icachePkg::wordBits +: icachePkg::wordBits];
            fetchRsp.hit  <= 1'b1;
        end else if (state == icachePkg::stFill) begin
            fetchRsp.data <= blockReg[wordSel*icachePkg::wordBits +: icachePkg::wordBits];
            fetchRsp.hit  <= 1'b0;
        end
    end

    // a new refill waits until memory has dropped the previous ack
    refillAfterDrop: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(refillValid) |-> !refillAck
    ) else $error("fetchController: refill request raised while ack still high");

endmodule

// File: hw/icacheTop.sv
// ---------------------------------------------------------------------------
// Instruction cache top level. Fetch port on one side, block refill port
// toward backing memory on the other; sets the cache geometry.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module icacheTop #(
    parameter int setCount = 16,
    parameter int wayCount = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetchValid,
    input  icachePkg::fetchReqT  fetchReq,
    output logic                 fetchAck,
    output icachePkg::fetchRspT  fetchRsp,
    output logic                 refillValid,
    output icachePkg::refillReqT refillReq,
    input  logic                 refillAck,
    input  icachePkg::refillRspT refillRsp
);

    // controller to array link
    icachePkg::arrayOpT                  op;
    logic [icachePkg::blockAddrBits-1:0] lookupAddr;
    logic [icachePkg::blockBits-1:0]     fillBlock;
    logic                                hit;
    logic [icachePkg::blockBits-1:0]     hitBlock;

    fetchController ctrl (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchReq    (fetchReq),
        .fetchAck    (fetchAck),
        .fetchRsp    (fetchRsp),
        .refillValid (refillValid),
        .refillReq   (refillReq),
        .refillAck   (refillAck),
        .refillRsp   (refillRsp),
        .op          (op),
        .lookupAddr  (lookupAddr),
        .fillBlock   (fillBlock),
        .hit         (hit),
        .hitBlock    (hitBlock)
    );

    icacheArray #(
        .setCount (setCount),
        .wayCount (wayCount)
    ) store (
        .clk        (clk),
        .rst        (rst),
        .op         (op),
        .lookupAddr (lookupAddr),
        .fillBlock  (fillBlock),
        .hit        (hit),
        .hitBlock   (hitBlock)
    );

endmodule

// File: tests/memResponder.sv
// ---------------------------------------------------------------------------
// Backing-memory model for the refill port. Answers each block request after
// a random delay of 1 to 4 cycles with data derived from the word address.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module memResponder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 refillValid,
    input  icachePkg::refillReqT refillReq,
    output logic                 refillAck,
    output icachePkg::refillRspT refillRsp
);

    integer seed;
    int     delayLeft;
    logic   busy;

    initial begin
        seed = 32'h02bfe4cf;
    end

    // word k of block b holds (b*4+k) xor a fixed pattern
    function automatic logic [icachePkg::blockBits-1:0] makeBlock(
        input logic [icachePkg::blockAddrBits-1:0] blockAddr
    );
        logic [icachePkg::blockBits-1:0] block;
        block = '0;
        for (int k = 0; k < icachePkg::blockWords; k++) begin
            block[k*icachePkg::wordBits +: icachePkg::wordBits] =
                {2'b00, blockAddr, k[1:0]} ^ 32'hA5A5_0000;
        end
        return block;
    endfunction

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            refillAck <= 1'b0;
            refillRsp <= '0;
            busy      <= 1'b0;
            delayLeft <= 0;
        end else if (!busy) begin
            // new request only once the previous ack is down
            if (refillValid && !refillAck) begin
                busy      <= 1'b1;
                delayLeft <= 1 + ({$random(seed)} % 4);
            end
            if (!refillValid && refillAck) begin
                refillAck <= 1'b0;
            end
        end else if (delayLeft > 1) begin
            delayLeft <= delayLeft - 1;
        end else begin
            refillRsp.block <= makeBlock(refillReq.blockAddr);
            refillAck       <= 1'b1;
            busy            <= 1'b0;
        end
    end

endmodule

// File: tests/icacheTb.sv
// ---------------------------------------------------------------------------
// Testbench for the instruction cache. Runs directed and random fetches
// against a reference model; concurrent assertions compare the responses.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module icacheTb;

    localparam int setCount = 16;
    localparam int wayCount = 4;
    localparam int indexBits = $clog2(setCount);
    localparam int tagBits = 32 - indexBits - 4;
    localparam int randomFetches = 200;
    localparam int fetchTotal = 2 + 12 + randomFetches;
    localparam int cycleLimit = 40 * fetchTotal + 100;

    logic                 clk;
    logic                 rst;
    logic                 fetchValid;
    icachePkg::fetchReqT  fetchReq;
    logic                 fetchAck;
    icachePkg::fetchRspT  fetchRsp;
    logic                 refillValid;
    icachePkg::refillReqT refillReq;
    logic                 refillAck;
    icachePkg::refillRspT refillRsp;

    icachePkg::fetchRspT expRsp;
    string               testName;
    int                  errorCount;
    int                  issued;
    int                  cycleCount;
    integer              seed;

    // reference model of valid, tag and MRU bits
    logic [wayCount-1:0] modelValid  [setCount];
    logic [wayCount-1:0] modelStatus [setCount];
    logic [tagBits-1:0]  modelTag    [setCount][wayCount];

    // five tags into set 5, interleaved hits, then re-fetch all of them
    int replaceTags [12] = '{1, 2, 3, 4, 2, 1, 5, 1, 2, 4, 5, 3};

    icacheTop #(
        .setCount (setCount),
        .wayCount (wayCount)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchReq    (fetchReq),
        .fetchAck    (fetchAck),
        .fetchRsp    (fetchRsp),
        .refillValid (refillValid),
        .refillReq   (refillReq),
        .refillAck   (refillAck),
        .refillRsp   (refillRsp)
    );

    memResponder mem (
        .clk         (clk),
        .rst         (rst),
        .refillValid (refillValid),
        .refillReq   (refillReq),
        .refillAck   (refillAck),
        .refillRsp   (refillRsp)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // predict the response and advance the model
    task automatic predictFetch(input logic [31:0] addr,
                                output icachePkg::fetchRspT prediction);
        logic [indexBits-1:0] set;
        logic [tagBits-1:0]   tag;
        logic [wayCount-1:0]  touchMask;
        int                   way;
        set = addr[indexBits+3:4];
        tag = addr[31:indexBits+4];
        way = -1;
        for (int w = 0; w < wayCount; w++) begin
            if (way < 0 && modelValid[set][w] && modelTag[set][w] == tag) begin
                way = w;
            end
        end
        prediction.hit  = (way >= 0);
        prediction.data = {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
        if (way < 0) begin
            // first invalid way, else first way with a clear MRU bit
            for (int w = 0; w < wayCount; w++) begin
                if (way < 0 && !modelValid[set][w]) begin
                    way = w;
                end
            end
            for (int w = 0; w < wayCount; w++) begin
                if (way < 0 && !modelStatus[set][w]) begin
                    way = w;
                end
            end
            modelValid[set][way] = 1'b1;
            modelTag[set][way]   = tag;
        end
        touchMask      = '0;
        touchMask[way] = 1'b1;
        modelStatus[set] = modelStatus[set] | touchMask;
        if (&modelStatus[set]) begin
            modelStatus[set] = touchMask;
        end
    endtask

    // one four-phase fetch, outputs sampled on the falling edge
    task automatic issueFetch(input logic [31:0] addr);
        icachePkg::fetchRspT prediction;
        predictFetch(addr, prediction);
        @(posedge clk);
        fetchReq.addr <= addr;
        fetchValid    <= 1'b1;
        expRsp        <= prediction;
        do @(negedge clk); while (!fetchAck);
        @(posedge clk);
        fetchValid <= 1'b0;
        do @(negedge clk); while (fetchAck);
        issued++;
    endtask

    resetQuiet: assert property (
        @(posedge clk) (!rst || $rose(rst)) |-> (!fetchAck && !refillValid)
    ) else begin
        errorCount++;
        $display("fetch ack or refill valid high during reset");
    end

    rspMatch: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(fetchAck) |-> (fetchRsp == expRsp)
    ) else begin
        errorCount++;
        $display("Error %s: expected data %h hit %0b, actual data %h hit %0b",
                 testName, expRsp.data, expRsp.hit, fetchRsp.data, fetchRsp.hit);
    end

    hitLatency: assert property (
        @(posedge clk) disable iff (!rst)
        ($rose(fetchAck) && expRsp.hit) |-> ($past(fetchValid, 2) && !$past(fetchValid, 3))
    ) else begin
        errorCount++;
        $display("%s: hit answered later or earlier than 2 cycles", testName);
    end

    rspHeld: assert property (
        @(posedge clk) disable iff (!rst)
        (fetchAck && fetchValid) |=> (fetchAck && $stable(fetchRsp))
    ) else begin
        errorCount++;
        $display("%s: response dropped or changed while fetch valid high", testName);
    end

    ackRelease: assert property (
        @(posedge clk) disable iff (!rst)
        (fetchAck && !fetchValid) |=> !fetchAck
    ) else begin
        errorCount++;
        $display("%s: fetch ack stayed high after fetch valid dropped", testName);
    end

    noRefillOnHit: assert property (
        @(posedge clk) disable iff (!rst)
        ((fetchValid || fetchAck) && expRsp.hit) |-> !refillValid
    ) else begin
        errorCount++;
        $display("%s: refill requested during a hit", testName);
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d fetches done", cycleLimit, issued);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] addr;
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchReq   = '0;
        expRsp     = '0;
        errorCount = 0;
        issued     = 0;
        cycleCount = 0;
        seed       = 32'h02bfe4cf;
        testName   = "reset";
        for (int s = 0; s < setCount; s++) begin
            modelValid[s]  = '0;
            modelStatus[s] = '0;
        end
        #10 rst = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);

        testName = "missThenHit";
        issueFetch(32'h0000_1234);
        issueFetch(32'h0000_1238);

        testName = "replacement";
        for (int i = 0; i < 12; i++) begin
            issueFetch(replaceTags[i] * 256 + 5 * 16 + (i % 4) * 4);
        end

        testName = "randomStream";
        for (int i = 0; i < randomFetches; i++) begin
            addr = {$random(seed)} & 32'h0000_07FF;
            issueFetch(addr);
        end

        repeat (2) @(posedge clk);
        $display("Fetches %0d, errors %0d", issued, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
hw/icachePkg.sv
hw/icacheArray.sv
hw/fetchController.sv
hw/icacheTop.sv
tests/memResponder.sv
tests/icacheTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the instruction cache testbench with Verilator.
# Exits 0 only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module icacheTb -f project.f -o icacheSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/icacheSim > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $SIM_LOG"
    exit 1
fi
